// ==== include/fdc_macros.svh ====
`ifndef FDC_MACROS_SVH
`define FDC_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
`define FDC_DATA_W              8       // Host and SRAM data
`define FDC_ADDR_W              19      // 512K x 8 SRAM

////////////////////////////////////////////////////////////////////////////
// Register map, low address byte only
`define FDC_REG_ADDR_LOW        8'h00   // SRAM address 7:0
`define FDC_REG_ADDR_HIGH       8'h01   // SRAM address 15:8
`define FDC_REG_ADDR_UPPER      8'h02   // SRAM address 18:16
`define FDC_REG_SRAM_DATA       8'h03   // SRAM data port, auto-increment
`define FDC_REG_DRIVE_CTRL      8'h04   // Drive control, write side
`define FDC_REG_STATUS2         8'h0F
`define FDC_REG_SCRATCH         8'h30   // Bus test scratchpad
`define FDC_REG_SCRATCH_INV     8'h31   // Scratchpad, inverted on read
`define FDC_REG_STEP_RATE       8'hF0   // Step slot period in ticks, minus one
`define FDC_REG_STEP_CMD        8'hFF   // Direction in bit 7, count in 6:0

// Microcode identity, read side of 0x04..0x07
`define FDC_REG_ID_TYPE_L       8'h04
`define FDC_REG_ID_TYPE_H       8'h05
`define FDC_REG_ID_VER_L        8'h06
`define FDC_REG_ID_VER_H        8'h07

////////////////////////////////////////////////////////////////////////////
// Microcode identity values
`define FDC_MCO_TYPE            16'hDD55
`define FDC_MCO_VERSION         16'h001A

// 250us at a 40MHz master clock
`define FDC_TICK_DIV_DEFAULT    10000

`endif

// ==== src/fdc_pkg.sv ====
`default_nettype none

`include "fdc_macros.svh"

package fdc_pkg;

	// One host or SRAM data byte
	typedef logic [`FDC_DATA_W-1:0] fdc_byte_t;

	// SRAM word address
	typedef logic [`FDC_ADDR_W-1:0] sram_addr_t;

	// Memory write controller
	typedef enum logic [2:0] {
		MWC_IDLE,       // OE on, waiting for a data write
		MWC_OE_OFF,     // Turn the bus around, load data
		MWC_WRITE,      // WE low
		MWC_WRITE_END,  // WE back high
		MWC_INC_ADDR    // Step the address counter
	} mwc_state_t;

	// Head stepper
	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_PULSE,     // fd_step low for this cycle
		STEP_WAIT       // Between slots
	} step_state_t;

endpackage

`default_nettype wire

// ==== src/host_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_macros.svh"

module host_bus import fdc_pkg::*; (
	input  wire logic      CLK_MASTER,
	input  wire logic      rst,
	input  wire fdc_byte_t pmd_in,
	input  wire logic      pmalh,
	input  wire logic      pmall,
	input  wire logic      pmrd,
	input  wire logic      pmwr,
	output fdc_byte_t      pmd_out,
	input  wire fdc_byte_t sram_dq_in,
	input  wire sram_addr_t sram_a,
	input  wire logic      addr_empty,
	input  wire logic      addr_full,
	input  wire logic      stepping,
	input  wire logic      fd_index,
	input  wire logic      fd_track0,
	input  wire logic      fd_wrprot,
	input  wire logic      fd_rdy,
	input  wire logic      fd_dens_in,
	output logic           addr_ld_low,
	output logic           addr_ld_high,
	output logic           addr_ld_upper,
	output logic           data_wr,
	output logic           rd_done,
	output fdc_byte_t      wr_data,
	output fdc_byte_t      drive_control,
	output fdc_byte_t      step_rate,
	output fdc_byte_t      step_cmd_data,
	output logic           step_cmd
);

	localparam logic [15:0] mco_type    = `FDC_MCO_TYPE;
	localparam logic [15:0] mco_version = `FDC_MCO_VERSION;

	logic        wr_meta, wr_sync, wr_last;    // PMWR synchroniser + edge
	logic        rd_meta, rd_sync, rd_last;    // PMRD synchroniser + edge
	logic        wr_pulse, rd_fall;
	fdc_byte_t   addr_hi, addr_lo;
	logic [15:0] host_addr;
	fdc_byte_t   reg_addr;                     // Decoded part of host_addr
	fdc_byte_t   scratch;
	fdc_byte_t   dq_lat;                       // SRAM read data for the host

////////////////////////////////////////////////////////////////////////////
// Strobe synchronisers and address latch

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			{wr_meta, wr_sync, wr_last} <= 3'b000;
			{rd_meta, rd_sync, rd_last} <= 3'b000;
			addr_hi <= '0;
			addr_lo <= '0;
		end else begin
			{wr_meta, wr_sync, wr_last} <= {pmwr, wr_meta, wr_sync};
			{rd_meta, rd_sync, rd_last} <= {pmrd, rd_meta, rd_sync};
			if (pmalh) addr_hi <= pmd_in;
			if (pmall) addr_lo <= pmd_in;
		end
	end

	assign wr_pulse  = wr_sync & ~wr_last;     // Two clocks after PMWR rises
	assign rd_fall   = ~rd_sync & rd_last;     // End of a host read
	assign host_addr = {addr_hi, addr_lo};
	assign reg_addr  = host_addr[7:0];         // High byte ignored

////////////////////////////////////////////////////////////////////////////
// Register writes and strobes to the other blocks

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			drive_control <= '0;                // All FD outputs inactive
			step_rate     <= '0;
			addr_ld_low   <= 1'b0;
			addr_ld_high  <= 1'b0;
			addr_ld_upper <= 1'b0;
			data_wr       <= 1'b0;
			rd_done       <= 1'b0;
			step_cmd      <= 1'b0;
		end else begin
			if (wr_pulse && reg_addr == `FDC_REG_DRIVE_CTRL) drive_control <= pmd_in;
			if (wr_pulse && reg_addr == `FDC_REG_STEP_RATE)  step_rate     <= pmd_in;
			addr_ld_low   <= wr_pulse && (reg_addr == `FDC_REG_ADDR_LOW);
			addr_ld_high  <= wr_pulse && (reg_addr == `FDC_REG_ADDR_HIGH);
			addr_ld_upper <= wr_pulse && (reg_addr == `FDC_REG_ADDR_UPPER);
			data_wr       <= wr_pulse && (reg_addr == `FDC_REG_SRAM_DATA);
			step_cmd      <= wr_pulse && (reg_addr == `FDC_REG_STEP_CMD);
			rd_done       <= rd_fall && (reg_addr == `FDC_REG_SRAM_DATA); // Post-read inc
		end
	end

	// Payload side, aligned with the strobes above
	always_ff @(posedge CLK_MASTER) begin
		if (wr_pulse) wr_data <= pmd_in;
		if (wr_pulse && reg_addr == `FDC_REG_SCRATCH) scratch <= pmd_in;
		if (wr_pulse && reg_addr == `FDC_REG_STEP_CMD) step_cmd_data <= pmd_in;
		// Follow the SRAM until the host read starts, then hold
		if (!rd_sync && reg_addr == `FDC_REG_SRAM_DATA) dq_lat <= sram_dq_in;
	end

////////////////////////////////////////////////////////////////////////////
// Readback multiplexer

	always_comb begin
		case (reg_addr)
			`FDC_REG_ADDR_LOW:    pmd_out = sram_a[7:0];
			`FDC_REG_ADDR_HIGH:   pmd_out = sram_a[15:8];
			`FDC_REG_ADDR_UPPER:  pmd_out = {5'b00000, sram_a[18:16]};
			`FDC_REG_SRAM_DATA:   pmd_out = dq_lat;
			`FDC_REG_ID_TYPE_L:   pmd_out = mco_type[7:0];
			`FDC_REG_ID_TYPE_H:   pmd_out = mco_type[15:8];
			`FDC_REG_ID_VER_L:    pmd_out = mco_version[7:0];
			`FDC_REG_ID_VER_H:    pmd_out = mco_version[15:8];
			`FDC_REG_STATUS2:     pmd_out = {fd_index, fd_track0, fd_wrprot, fd_rdy,
				fd_dens_in, stepping, addr_empty, addr_full};
			`FDC_REG_SCRATCH:     pmd_out = scratch;
			`FDC_REG_SCRATCH_INV: pmd_out = ~scratch;
			default:              pmd_out = '0;
		endcase
	end

	// Host never reads and writes at once
	a_no_rd_wr: assert property (@(posedge CLK_MASTER) disable iff (rst) !(pmwr && pmrd));

endmodule

`default_nettype wire

// ==== src/sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_macros.svh"

module sram_ctrl import fdc_pkg::*; (
	input  wire logic      CLK_MASTER,
	input  wire logic      rst,
	input  wire logic      addr_ld_low,
	input  wire logic      addr_ld_high,
	input  wire logic      addr_ld_upper,
	input  wire logic      data_wr,
	input  wire logic      rd_done,
	input  wire fdc_byte_t wr_data,
	output sram_addr_t     sram_a,
	output fdc_byte_t      sram_dq_out,
	output logic           sram_we_n,
	output logic           sram_oe_n,
	output logic           addr_empty,
	output logic           addr_full
);

	mwc_state_t state;
	logic       addr_inc;                    // From either the MWC or a host read

////////////////////////////////////////////////////////////////////////////
// Memory write controller

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			state     <= MWC_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;                    // SRAM drives the bus at rest
		end else begin
			case (state)
				MWC_IDLE: begin
					sram_we_n <= 1'b1;
					sram_oe_n <= 1'b0;
					if (data_wr) state <= MWC_OE_OFF;
				end
				MWC_OE_OFF: begin
					sram_oe_n <= 1'b1;                // Release bus before driving it
					state     <= MWC_WRITE;
				end
				MWC_WRITE: begin
					sram_we_n <= 1'b0;                // One cycle write pulse
					state     <= MWC_WRITE_END;
				end
				MWC_WRITE_END: begin
					sram_we_n <= 1'b1;
					state     <= MWC_INC_ADDR;
				end
				MWC_INC_ADDR: state <= MWC_IDLE;     // Counter steps on this cycle
				default:      state <= MWC_IDLE;
			endcase
		end
	end

	// Write data is loaded as OE goes inactive
	always_ff @(posedge CLK_MASTER) begin
		if (state == MWC_OE_OFF) sram_dq_out <= wr_data;
	end

////////////////////////////////////////////////////////////////////////////
// Address counter

	assign addr_inc = (state == MWC_INC_ADDR) || rd_done;

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			sram_a <= '0;
		end else if (addr_ld_low) begin
			sram_a[7:0] <= wr_data;
		end else if (addr_ld_high) begin
			sram_a[15:8] <= wr_data;
		end else if (addr_ld_upper) begin
			sram_a[`FDC_ADDR_W-1:16] <= wr_data[`FDC_ADDR_W-17:0];  // Top bits dropped
		end else if (addr_inc) begin
			sram_a <= sram_a + sram_addr_t'(1);  // Wraps past the top
		end
	end

	assign addr_empty = (sram_a == '0);
	assign addr_full  = &sram_a;

	// Bus turned around before any write
	a_we_oe: assert property (@(posedge CLK_MASTER) disable iff (rst)
		!sram_we_n |-> sram_oe_n);

	a_state: assert property (@(posedge CLK_MASTER) disable iff (rst)
		state inside {MWC_IDLE, MWC_OE_OFF, MWC_WRITE, MWC_WRITE_END, MWC_INC_ADDR});

endmodule

`default_nettype wire

// ==== src/step_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_macros.svh"

module step_ctrl import fdc_pkg::*; #(
	parameter int unsigned TICK_DIV = `FDC_TICK_DIV_DEFAULT
) (
	input  wire logic      CLK_MASTER,
	input  wire logic      rst,
	input  wire fdc_byte_t step_rate,
	input  wire logic      step_cmd,
	input  wire fdc_byte_t step_cmd_data,
	input  wire logic      fd_track0,        // Active low
	output logic           fd_step,
	output logic           fd_dir,
	output logic           stepping
);

	localparam int TICK_W = $clog2(TICK_DIV + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;                 // One cycle every 250us
	fdc_byte_t         rate_cnt;
	logic              slot;                 // Step opportunity
	step_state_t       state;
	logic [6:0]        steps_left;
	logic              dir_in;               // 1 = towards the spindle

////////////////////////////////////////////////////////////////////////////
// Timebase and step-rate divider

	assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));
	assign slot = tick && (rate_cnt == step_rate);

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			tick_cnt <= '0;
			rate_cnt <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (slot) rate_cnt <= '0;
			else if (tick) rate_cnt <= rate_cnt + 1'b1;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Stepper

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			state      <= STEP_IDLE;
			fd_step    <= 1'b1;
			steps_left <= '0;
			dir_in     <= 1'b0;
		end else if (step_cmd) begin
			// New command restarts the stepper
			fd_step    <= 1'b1;
			dir_in     <= step_cmd_data[7];
			steps_left <= step_cmd_data[6:0];
			state      <= (step_cmd_data[6:0] != '0) ? STEP_WAIT : STEP_IDLE;
		end else begin
			case (state)
				STEP_WAIT: begin
					if (!dir_in && !fd_track0) begin
						state <= STEP_IDLE;              // Outward stop at track 0
					end else if (steps_left == '0) begin
						state <= STEP_IDLE;
					end else if (slot) begin
						fd_step <= 1'b0;
						state   <= STEP_PULSE;
					end
				end
				STEP_PULSE: begin
					fd_step    <= 1'b1;
					steps_left <= steps_left - 1'b1;
					state      <= STEP_WAIT;
				end
				default: state <= STEP_IDLE;
			endcase
		end
	end

	assign stepping = (state != STEP_IDLE);
	assign fd_dir   = ~dir_in;               // Drive input is active low

	// Step pulses only inside a command
	a_step_busy: assert property (@(posedge CLK_MASTER) disable iff (rst)
		!fd_step |-> stepping);

endmodule

`default_nettype wire

// ==== src/fdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_macros.svh"

module fdc_top import fdc_pkg::*; #(
	parameter int unsigned TICK_DIV = `FDC_TICK_DIV_DEFAULT
) (
	input  wire logic       CLK_MASTER,
	input  wire logic       rst,
	input  wire fdc_byte_t  pmd_in,
	input  wire logic       pmalh,
	input  wire logic       pmall,
	input  wire logic       pmrd,
	input  wire logic       pmwr,
	output fdc_byte_t       pmd_out,
	output sram_addr_t      sram_a,
	input  wire fdc_byte_t  sram_dq_in,
	output fdc_byte_t       sram_dq_out,     // Valid while sram_oe_n is high
	output logic            sram_we_n,
	output logic            sram_oe_n,
	input  wire logic       fd_index,
	input  wire logic       fd_track0,
	input  wire logic       fd_wrprot,
	input  wire logic       fd_rdy,
	input  wire logic       fd_dens_in,
	input  wire logic       fd_rddata,       // No reader on this board build
	output logic            fd_dens_out,
	output logic            fd_inuse,
	output logic [3:0]      fd_drvsel,
	output logic            fd_moten,
	output logic            fd_sidesel,
	output logic            fd_step,
	output logic            fd_dir,
	output logic            fd_wrdata,
	output logic            fd_wrgate
);

	fdc_byte_t rd_byte, wr_data, drive_control, step_rate, step_cmd_data;
	logic      addr_ld_low, addr_ld_high, addr_ld_upper, data_wr, rd_done;
	logic      addr_empty, addr_full, step_cmd, stepping;

	host_bus u_host_bus (
		.CLK_MASTER, .rst, .pmd_in, .pmalh, .pmall, .pmrd, .pmwr,
		.pmd_out(rd_byte), .sram_dq_in, .sram_a, .addr_empty, .addr_full, .stepping,
		.fd_index, .fd_track0, .fd_wrprot, .fd_rdy, .fd_dens_in,
		.addr_ld_low, .addr_ld_high, .addr_ld_upper, .data_wr, .rd_done, .wr_data,
		.drive_control, .step_rate, .step_cmd_data, .step_cmd
	);

	sram_ctrl u_sram_ctrl (
		.CLK_MASTER, .rst, .addr_ld_low, .addr_ld_high, .addr_ld_upper, .data_wr,
		.rd_done, .wr_data, .sram_a, .sram_dq_out, .sram_we_n, .sram_oe_n,
		.addr_empty, .addr_full
	);

	step_ctrl #(.TICK_DIV(TICK_DIV)) u_step_ctrl (
		.CLK_MASTER, .rst, .step_rate, .step_cmd, .step_cmd_data, .fd_track0,
		.fd_step, .fd_dir, .stepping
	);

	assign pmd_out = pmrd ? rd_byte : '0;    // Host bus driven only during reads

	// Drive control pins are active low
	assign fd_dens_out = ~drive_control[0];
	assign fd_inuse    = ~drive_control[1];
	assign fd_drvsel   = ~drive_control[5:2];
	assign fd_moten    = ~drive_control[6];
	assign fd_sidesel  = ~drive_control[7];
	assign fd_wrdata   = 1'b1;               // Writer absent, held inactive
	assign fd_wrgate   = 1'b1;

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic CLK_MASTER,
	output logic rst
);

	initial begin
		CLK_MASTER = 1'b0;
		forever #(PERIOD_NS / 2) CLK_MASTER = ~CLK_MASTER;
	end

	// Reset held over the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK_MASTER);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/tb_fdc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_macros.svh"

module tb_fdc import fdc_pkg::*; ();

	localparam int PERIOD_NS    = 100;
	localparam int TICK_DIV_TB  = 20;        // Short timebase for simulation
	localparam int NUM_ADDRS    = 8;
	localparam int NUM_BYTES    = 16;
	localparam int MAX_STEPS    = 10;
	localparam int MAX_RATE     = 3;
	localparam int BUS_OP_CYC   = 16;        // Address strobe, 4 strobe clocks, 8 idle
	localparam int BUS_OPS      = 7 + NUM_ADDRS * 7 + 2 * (NUM_BYTES + 3) + 1 + 6;
	localparam int STEP_CYC     = (MAX_STEPS + 1) * (MAX_RATE + 1) * TICK_DIV_TB;
	localparam int RUN_CYC      = BUS_OPS * BUS_OP_CYC + 2 * STEP_CYC + 4 * BUS_OP_CYC;
	localparam int WATCHDOG_CYC = 2 * RUN_CYC + 10;

	logic       CLK_MASTER, rst;
	fdc_byte_t  pmd_in, pmd_out, sram_dq_in, sram_dq_out;
	logic       pmalh, pmall, pmrd, pmwr;
	sram_addr_t sram_a;
	logic       sram_we_n, sram_oe_n;
	logic       fd_index, fd_track0, fd_wrprot, fd_rdy, fd_dens_in, fd_rddata;
	logic       fd_dens_out, fd_inuse, fd_moten, fd_sidesel;
	logic [3:0] fd_drvsel;
	logic       fd_step, fd_dir, fd_wrdata, fd_wrgate;

	integer     seed;
	int         error_count;
	int         step_pulses;                 // Running count of fd_step low cycles
	logic       exp_dir;                     // Expected fd_dir during a pulse
	fdc_byte_t  sram_mem [0:(1 << `FDC_ADDR_W) - 1];

	clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) u_clk_gen (.CLK_MASTER, .rst);

	fdc_top #(.TICK_DIV(TICK_DIV_TB)) u_dut (
		.CLK_MASTER, .rst, .pmd_in, .pmalh, .pmall, .pmrd, .pmwr, .pmd_out,
		.sram_a, .sram_dq_in, .sram_dq_out, .sram_we_n, .sram_oe_n,
		.fd_index, .fd_track0, .fd_wrprot, .fd_rdy, .fd_dens_in, .fd_rddata,
		.fd_dens_out, .fd_inuse, .fd_drvsel, .fd_moten, .fd_sidesel,
		.fd_step, .fd_dir, .fd_wrdata, .fd_wrgate
	);

////////////////////////////////////////////////////////////////////////////
// SRAM model

	// Chip drives the bus only with OE low
	assign sram_dq_in = sram_oe_n ? sram_dq_out : sram_mem[sram_a];

	always @(posedge CLK_MASTER) begin
		if (!sram_we_n) sram_mem[sram_a] <= sram_dq_out;
	end

	initial begin
		for (int i = 0; i < (1 << `FDC_ADDR_W); i++) begin
			sram_mem[i] = i[7:0] ^ i[15:8] ^ {5'b00000, i[18:16]};  // Folded address
		end
	end

////////////////////////////////////////////////////////////////////////////
// Helpers

	task automatic check(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic fdc_byte_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic sram_addr_t rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return r[`FDC_ADDR_W-1:0];
	endfunction

	task automatic idle_bus();
		repeat (8) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);                   // Hand back where outputs are stable
	endtask

	// High address byte random, only the low byte is decoded
	task automatic set_addr(input fdc_byte_t reg_addr);
		@(posedge CLK_MASTER);
		pmd_in <= rand_byte();
		pmalh  <= 1'b1;
		@(posedge CLK_MASTER);
		pmalh  <= 1'b0;
		pmd_in <= reg_addr;
		pmall  <= 1'b1;
		@(posedge CLK_MASTER);
		pmall  <= 1'b0;
	endtask

	task automatic bus_write(input fdc_byte_t reg_addr, input fdc_byte_t data);
		set_addr(reg_addr);
		@(posedge CLK_MASTER);
		pmd_in <= data;
		pmwr   <= 1'b1;
		repeat (4) @(posedge CLK_MASTER);
		pmwr   <= 1'b0;
		idle_bus();
	endtask

	task automatic bus_read(input fdc_byte_t reg_addr, output fdc_byte_t data);
		set_addr(reg_addr);
		@(posedge CLK_MASTER);
		pmrd <= 1'b1;
		repeat (3) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);
		data = pmd_out;                          // Late in the read strobe
		@(posedge CLK_MASTER);
		pmrd <= 1'b0;
		idle_bus();
	endtask

	task automatic read_expect(input fdc_byte_t reg_addr, input fdc_byte_t exp,
		input string name);
		fdc_byte_t got;
		bus_read(reg_addr, got);
		check(name, got, exp);
	endtask

	task automatic load_addr(input sram_addr_t a);
		fdc_byte_t junk;
		junk = rand_byte();                      // Upper bits the counter must drop
		bus_write(`FDC_REG_ADDR_LOW, a[7:0]);
		bus_write(`FDC_REG_ADDR_HIGH, a[15:8]);
		bus_write(`FDC_REG_ADDR_UPPER, {junk[7:3], a[18:16]});
	endtask

////////////////////////////////////////////////////////////////////////////
// Monitors and watchdog

	always @(negedge CLK_MASTER) begin
		if (!rst) begin
			check("sram_we_n | sram_oe_n", sram_we_n | sram_oe_n, 1'b1);
			if (!fd_step) begin
				step_pulses++;
				check("fd_dir", fd_dir, exp_dir);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYC * PERIOD_NS);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYC);
		$display("RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

////////////////////////////////////////////////////////////////////////////
// Stimulus

	initial begin : stimulus
		fdc_byte_t  d, st, scratch, ctl, ctl_n;
		sram_addr_t start, a;
		fdc_byte_t  wr_bytes [NUM_BYTES];
		int         n, base;

		seed        = 32'ha840;
		error_count = 0;
		step_pulses = 0;
		exp_dir     = 1'b0;
		pmd_in      = '0;
		{pmalh, pmall, pmrd, pmwr} = 4'b0000;
		d           = rand_byte();
		{fd_index, fd_wrprot, fd_rdy, fd_dens_in} = d[3:0];  // Static drive status
		fd_track0   = 1'b1;                      // Head away from track 0
		fd_rddata   = 1'b1;

		while (rst !== 1'b0) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);

		// Reset state
		check("sram_we_n", sram_we_n, 1'b1);
		check("sram_oe_n", sram_oe_n, 1'b0);
		check("fd_step", fd_step, 1'b1);
		check("sram_a", sram_a, '0);
		check("fd_drvsel", fd_drvsel, 4'hF);
		check("fd_wrdata, fd_wrgate", {fd_wrdata, fd_wrgate}, 2'b11);

		// Microcode identity and scratchpad
		read_expect(`FDC_REG_ID_TYPE_L, 8'h55, "pmd_out @ 0x04");
		read_expect(`FDC_REG_ID_TYPE_H, 8'hDD, "pmd_out @ 0x05");
		read_expect(`FDC_REG_ID_VER_L, 8'h1A, "pmd_out @ 0x06");
		read_expect(`FDC_REG_ID_VER_H, 8'h00, "pmd_out @ 0x07");
		scratch = rand_byte();
		bus_write(`FDC_REG_SCRATCH, scratch);
		read_expect(`FDC_REG_SCRATCH, scratch, "pmd_out @ 0x30");
		read_expect(`FDC_REG_SCRATCH_INV, ~scratch, "pmd_out @ 0x31");

		// Address counter loads, empty and full flags
		for (int i = 0; i < NUM_ADDRS; i++) begin
			a = (i == 0) ? '0 : (i == 1) ? '1 : rand_addr();
			load_addr(a);
			read_expect(`FDC_REG_ADDR_LOW, a[7:0], "pmd_out @ 0x00");
			read_expect(`FDC_REG_ADDR_HIGH, a[15:8], "pmd_out @ 0x01");
			read_expect(`FDC_REG_ADDR_UPPER, {5'b00000, a[18:16]}, "pmd_out @ 0x02");
			read_expect(`FDC_REG_STATUS2, {fd_index, fd_track0, fd_wrprot, fd_rdy,
				fd_dens_in, 1'b0, a == '0, &a}, "STATUS2");
		end

		// SRAM fill
		start = rand_addr();
		load_addr(start);
		for (int i = 0; i < NUM_BYTES; i++) begin
			wr_bytes[i] = rand_byte();
			bus_write(`FDC_REG_SRAM_DATA, wr_bytes[i]);
			a = start + sram_addr_t'(i + 1);
			check("sram_a after write", sram_a, a);
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			a = start + sram_addr_t'(i);
			check("sram_mem", sram_mem[a], wr_bytes[i]);
		end

		// SRAM readback, post-read increment
		load_addr(start);
		for (int i = 0; i < NUM_BYTES; i++) begin
			read_expect(`FDC_REG_SRAM_DATA, wr_bytes[i], "pmd_out @ 0x03");
			a = start + sram_addr_t'(i + 1);
			check("sram_a after read", sram_a, a);
		end

		// Drive control pins, active low
		ctl = rand_byte();
		bus_write(`FDC_REG_DRIVE_CTRL, ctl);
		ctl_n = ~ctl;
		check("fd_dens_out", fd_dens_out, ctl_n[0]);
		check("fd_inuse", fd_inuse, ctl_n[1]);
		check("fd_drvsel", fd_drvsel, ctl_n[5:2]);
		check("fd_moten", fd_moten, ctl_n[6]);
		check("fd_sidesel", fd_sidesel, ctl_n[7]);

		// Inward stepping
		d = rand_byte();
		n = 3 + (d % 8);                         // Long enough to catch in STATUS2
		bus_write(`FDC_REG_STEP_RATE, rand_byte() & 8'(MAX_RATE));
		base    = step_pulses;
		exp_dir = 1'b0;
		bus_write(`FDC_REG_STEP_CMD, {1'b1, 7'(n)});
		bus_read(`FDC_REG_STATUS2, st);
		check("STATUS2[2] while stepping", st[2], 1'b1);
		while (st[2]) bus_read(`FDC_REG_STATUS2, st);
		check("fd_step pulse count", step_pulses - base, n);

		// Outward at track 0 stops at once
		@(posedge CLK_MASTER);
		fd_track0 <= 1'b0;
		base    = step_pulses;
		exp_dir = 1'b1;
		bus_write(`FDC_REG_STEP_CMD, {1'b0, 7'(n)});
		bus_read(`FDC_REG_STATUS2, st);
		check("STATUS2[2] outward at track 0", st[2], 1'b0);
		check("fd_step pulse count outward", step_pulses - base, 0);

		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
src/fdc_pkg.sv
src/host_bus.sv
src/sram_ctrl.sv
src/step_ctrl.sv
src/fdc_top.sv
sim/clk_gen.sv
sim/tb_fdc.sv
